//--- sources.f
disp_pkg.sv
display_regs.sv
video_timing.sv
pixel_stream.sv
display_top.sv
display_chk.sv
tb_display.sv

//--- Bender.yml
package:
  name: display_timing

sources:
  - disp_pkg.sv
  - display_regs.sv
  - video_timing.sv
  - pixel_stream.sv
  - display_top.sv
  - target: simulation
    files:
      - display_chk.sv
      - tb_display.sv

//--- tb_display.sv
// Directed testbench for display_top with a credit-based pixel source and line, pixel and flag checks
`timescale 1ns/10ps

module tb_display;
    import disp_pkg::*;

    localparam int FrameClks = 313 * 120 * 16;       // Longest field plus half line
    localparam int MaxCycles = 14 * FrameClks;       // About 11 fields of tests plus margin

    // 30 MHz 360 wide at 60 Hz, 30 MHz 384 wide at 50 Hz, and 28 MHz
    localparam mode_t ModeA = '{sm: 1'b0, cf: 1'b1, st: 1'b1, cm: 1'b0, fd: 1'b1};
    localparam mode_t ModeB = '{sm: 1'b0, cf: 1'b1, st: 1'b0, cm: 1'b0, fd: 1'b0};
    localparam mode_t ModeC = '{sm: 1'b0, cf: 1'b0, st: 1'b0, cm: 1'b0, fd: 1'b0};

    logic       clk = 1'b0;
    logic       reset;
    reg_write_t reg_wr;
    logic       pix_valid;
    pixel_t     pix_data;
    logic       credit_return;
    pixel_t     pix_out;
    logic       pix_out_valid;
    logic       hsync;
    logic       vsync;
    logic       hblank;
    logic       vblank;
    logic       parity;
    logic       underflow;

    integer seed = 32;
    int     cycles = 0;
    int     pixel_errors = 0;
    int     count_errors = 0;
    int     flag_errors = 0;
    int     credits;
    int     sent;
    int     returned;
    logic   src_enable = 1'b0;
    logic   check_order = 1'b0;      // Compare strobed pixels with the sent pattern
    logic   check_border = 1'b0;     // Compare blanked output with the border color
    logic   strobe_border = 1'b0;    // Strobed pixels must show the border, source stopped
    logic [23:0] src_seq;
    logic [23:0] exp_seq;
    logic        hblank_q;
    pixel_t      border_color;

    display_top UUT (
        .clk           (clk),
        .reset         (reset),
        .reg_wr        (reg_wr),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .credit_return (credit_return),
        .pix_out       (pix_out),
        .pix_out_valid (pix_out_valid),
        .hsync         (hsync),
        .vsync         (vsync),
        .hblank        (hblank),
        .vblank        (vblank),
        .parity        (parity),
        .underflow     (underflow)
    );

    always #20 clk = ~clk;

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input string msg);
        if (got !== exp) begin
            pixel_errors++;
            $display("** Error at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        if (got != exp) begin
            count_errors++;
            $display("** Error at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            flag_errors++;
            $display("** Error at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // Pixel source, one transfer per credit, random gaps
    always @(posedge clk) begin
        int c;
        if (reset) begin
            credits   = PixFifoDepth;
            sent      = 0;
            returned  = 0;
            src_seq   = '0;
            pix_valid <= 1'b0;
            pix_data  <= '0;
        end else begin
            c = credits + int'(credit_return);
            if (credit_return) returned++;
            if (src_enable && c > 0 && ($random(seed) & 3) != 0) begin
                pix_valid <= 1'b1;
                pix_data  <= src_seq;
                src_seq   = src_seq + 24'd1;
                sent++;
                c--;
            end else begin
                pix_valid <= 1'b0;
            end
            credits = c;
            check_flag(returned <= sent, 1'b1, "credits returned exceed pixels sent");
        end
    end

    // Output monitor
    always @(posedge clk) begin
        if (reset) begin
            exp_seq  = '0;
            hblank_q = 1'b1;
        end else begin
            if (pix_out_valid && check_order) begin
                check_pixel(pix_out, exp_seq, "pixel out of order");
                exp_seq = exp_seq + 24'd1;
            end
            if (pix_out_valid && strobe_border) check_pixel(pix_out, border_color, "strobe color");
            if (check_border && hblank_q) check_pixel(pix_out, border_color, "blank color");
            hblank_q = hblank;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MaxCycles) begin
            $display("Timeout: run exceeded %0d clock cycles", MaxCycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic write_reg(input logic addr, input logic [23:0] data);
        @(posedge clk);
        reg_wr <= '{en: 1'b1, addr: addr, data: data};
        @(posedge clk);
        reg_wr <= '{en: 1'b0, addr: 1'b0, data: 24'h0};
    endtask

    task automatic wait_new_frame;
        @(posedge clk);
        while (!UUT.beam.new_frame) @(posedge clk);
    endtask

    task automatic apply_mode(input mode_t m);
        write_reg(AddrCommand, {19'b0, m});
        wait_new_frame();
        @(posedge clk);
    endtask

    task automatic wait_hsync_rise;
        logic prev;
        prev = hsync;
        @(posedge clk);
        while (!(hsync && !prev)) begin
            prev = hsync;
            @(posedge clk);
        end
    endtask

    // Clocks and output pixels from one hsync rise to the next
    task automatic count_line(output int clocks, output int pixels);
        logic prev;
        logic rise;
        wait_hsync_rise();
        clocks = 0;
        pixels = 0;
        prev   = hsync;
        do begin
            @(posedge clk);
            clocks++;
            if (pix_out_valid) pixels++;
            rise = hsync && !prev;
            prev = hsync;
        end while (!rise);
    endtask

    task automatic wait_active;
        @(posedge clk);
        while (vblank) @(posedge clk);
    endtask

    // Vsync high time in whole lines, vertical blank must cover it
    task automatic vsync_width_in_lines(input int line_clks);
        int clocks;
        while (vsync) @(posedge clk);
        while (!vsync) @(posedge clk);
        clocks = 0;
        while (vsync) begin
            @(posedge clk);
            clocks++;
            check_flag(vblank, 1'b1, "vblank during vsync");
        end
        check_count(clocks / line_clks, VSyncLines, "vsync lines");
    endtask

    task automatic line_length_per_crystal;
        int clocks;
        int pixels;
        apply_mode(ModeA);
        count_line(clocks, pixels);
        check_count(clocks, 120 * 16, "line length, 30 MHz 360 wide");
        check_flag(parity, 1'b1, "progressive parity");
        apply_mode(ModeB);
        count_line(clocks, pixels);
        check_count(clocks, 120 * 16, "line length, 30 MHz 384 wide");
        check_flag(parity, 1'b1, "progressive parity");
        apply_mode(ModeC);
        count_line(clocks, pixels);
        check_count(clocks, 112 * 16, "line length, 28 MHz");
        check_flag(parity, 1'b1, "progressive parity");
    endtask

    task automatic pixels_per_line;
        mode_t m;
        int    clocks;
        int    pixels;
        wait_active();
        count_line(clocks, pixels);
        check_count(pixels, 90 * 16 / 4, "pixels per line, 4 clock pixels");
        m    = ModeC;
        m.cm = 1'b1;
        apply_mode(m);
        wait_active();
        count_line(clocks, pixels);
        check_count(pixels, 90 * 16 / 2, "pixels per line, 2 clock pixels");
    endtask

    task automatic mode_change_at_frame;
        int clocks;
        int pixels;
        write_reg(AddrCommand, {19'b0, ModeA});
        repeat (3) begin
            count_line(clocks, pixels);
            check_count(clocks, 112 * 16, "line length before frame boundary");
        end
        wait_new_frame();
        count_line(clocks, pixels);
        check_count(clocks, 120 * 16, "line length after frame boundary");
    endtask

    task automatic interlace_parity;
        mode_t m;
        logic  last;
        m    = ModeA;
        m.sm = 1'b1;
        apply_mode(m);
        last = parity;
        repeat (3) begin
            wait_new_frame();
            check_flag(parity, !last, "interlace parity");
            last = parity;
        end
        vsync_width_in_lines(120 * 16);
    endtask

    task automatic underflow_and_credits;
        int clocks;
        int pixels;
        check_flag(underflow, 1'b0, "underflow with source running");
        check_order <= 1'b0;
        src_enable  <= 1'b0;
        while (!underflow) @(posedge clk);
        wait_active();
        @(posedge clk);
        strobe_border <= 1'b1;
        repeat (2) count_line(clocks, pixels);
        strobe_border <= 1'b0;
        check_flag(underflow, 1'b1, "underflow sticky");
        check_count(credits, PixFifoDepth, "credits after drain");
        check_count(returned, sent, "credits returned after drain");
    endtask

    initial begin
        reset     = 1'b1;
        reg_wr    = '{en: 1'b0, addr: 1'b0, data: 24'h0};
        pix_valid = 1'b0;
        pix_data  = '0;
        border_color = 24'h204060;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        write_reg(AddrBorder, border_color);
        @(posedge clk);
        check_border <= 1'b1;
        check_order  <= 1'b1;
        src_enable   <= 1'b1;

        line_length_per_crystal();
        pixels_per_line();
        mode_change_at_frame();
        interlace_parity();
        underflow_and_credits();

        $display("Errors: pixel %0d, count %0d, flag %0d", pixel_errors, count_errors,
                 flag_errors);
        if (pixel_errors + count_errors + flag_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- display_chk.sv
// Bound checker for display_top covering hsync width, blanked pixel output and credit accounting
`timescale 1ns/10ps

module display_chk (
    input logic            clk,
    input logic            reset,
    input disp_pkg::mode_t mode,
    input logic            hsync,
    input logic            hblank,
    input logic            pix_valid,
    input logic            pix_out_valid,
    input logic            credit_return
);
    import disp_pkg::*;

    int hs_len;         // Clocks hsync has been high
    int outstanding;    // Pixels sent and not yet credited back

    always_ff @(posedge clk) begin
        if (reset) begin
            hs_len      <= 0;
            outstanding <= 0;
        end else begin
            hs_len      <= hsync ? hs_len + 1 : 0;
            outstanding <= outstanding + int'(pix_valid) - int'(credit_return);
        end
    end

    // 30 MHz crystal has a 9 unit sync, 28 MHz has 8
    hsync_width: assert property (@(posedge clk) disable iff (reset)
        $fell(hsync) |-> hs_len == (mode.cf ? 9 : 8) * ClksPerCycle)
        else $error("hsync width %0d clocks", hs_len);

    no_pixel_in_hblank: assert property (@(posedge clk) disable iff (reset)
        !(pix_out_valid && hblank))
        else $error("pixel output during horizontal blank");

    credit_needs_pixel: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> outstanding > 0)
        else $error("credit returned with no pixel outstanding");

endmodule

bind display_top display_chk u_chk (
    .clk           (clk),
    .reset         (reset),
    .mode          (mode),
    .hsync         (hsync),
    .hblank        (hblank),
    .pix_valid     (pix_valid),
    .pix_out_valid (pix_out_valid),
    .credit_return (credit_return)
);

//--- display_top.sv
// Display controller top; register block, beam timing and pixel output joined to the external ports
`timescale 1ns/10ps

module display_top (
    input  logic                 clk,
    input  logic                 reset,
    input  disp_pkg::reg_write_t reg_wr,
    input  logic                 pix_valid,
    input  disp_pkg::pixel_t     pix_data,
    output logic                 credit_return,
    output disp_pkg::pixel_t     pix_out,
    output logic                 pix_out_valid,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 hblank,
    output logic                 vblank,
    output logic                 parity,
    output logic                 underflow
);
    import disp_pkg::*;

    mode_t  mode;      // Live mode, updated at frame boundary
    pixel_t border;
    beam_t  beam;

    display_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .reg_wr    (reg_wr),
        .new_frame (beam.new_frame),
        .mode      (mode),
        .border    (border)
    );

    video_timing u_timing (
        .clk   (clk),
        .reset (reset),
        .mode  (mode),
        .beam  (beam)
    );

    pixel_stream u_stream (
        .clk           (clk),
        .reset         (reset),
        .beam          (beam),
        .border        (border),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .credit_return (credit_return),
        .pix_out       (pix_out),
        .pix_out_valid (pix_out_valid),
        .underflow     (underflow)
    );

    assign hsync  = beam.hsync;
    assign vsync  = beam.vsync;
    assign hblank = beam.hblank;
    assign vblank = beam.vblank;
    assign parity = beam.parity;

endmodule

//--- pixel_stream.sv
// Pixel receive buffer with credit return and the registered output stage for pixel or border color
`timescale 1ns/10ps

module pixel_stream (
    input  logic             clk,
    input  logic             reset,
    input  disp_pkg::beam_t  beam,
    input  disp_pkg::pixel_t border,
    input  logic             pix_valid,
    input  disp_pkg::pixel_t pix_data,
    output logic             credit_return,
    output disp_pkg::pixel_t pix_out,
    output logic             pix_out_valid,
    output logic             underflow
);
    import disp_pkg::*;

    pixel_t fifo_mem [PixFifoDepth];

    logic [PixPtrW-1:0] wr_ptr;
    logic [PixPtrW-1:0] rd_ptr;
    logic [PixPtrW:0]   fill;      // Entries held, 0 to PixFifoDepth
    logic               empty;
    logic               pop;
    logic               blank;

    assign empty = (fill == '0);
    assign pop   = beam.new_pixel && !empty;   // One pixel per active strobe
    assign blank = beam.hblank || beam.vblank;

    // Source never sends without a credit, so no full check here
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            fifo_mem[wr_ptr] <= pix_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (pix_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;

            case ({pix_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
            pix_out_valid <= 1'b0;
            underflow     <= 1'b0;
        end else begin
            credit_return <= pop;             // One credit back per removed pixel
            pix_out_valid <= beam.new_pixel;
            if (beam.new_pixel && empty) begin
                underflow <= 1'b1;            // Sticky until reset
            end
        end
    end

    // Pixel holds for its whole period, border fills the blanked area
    always_ff @(posedge clk) begin
        if (beam.new_pixel) begin
            pix_out <= pop ? fifo_mem[rd_ptr] : border;
        end else if (blank) begin
            pix_out <= border;
        end
    end

endmodule

//--- video_timing.sv
// Beam timing generator; counters, syncs, blanking, field parity and pixel strobes from the live mode
`timescale 1ns/10ps

module video_timing (
    input  logic            clk,
    input  logic            reset,
    input  disp_pkg::mode_t mode,
    output disp_pkg::beam_t beam
);
    import disp_pkg::*;

    logic [1:0] h_sel;
    logic [1:0] v_sel;

    // Horizontal timing in clocks
    logic [12:0] h_total;
    logic [12:0] h_active;
    logic [12:0] h_start;
    logic [12:0] h_sync;
    logic [12:0] h_half;

    // Vertical timing in lines
    logic [8:0] v_total;
    logic [8:0] v_active;
    logic [8:0] v_start;
    logic [8:0] v_last;
    logic [8:0] v_sync;

    logic [12:0] video_x;
    logic [8:0]  video_y;
    logic        hsync;
    logic        vsync;
    logic        hblank;
    logic        vblank;
    logic        parity;
    logic        new_line;
    logic        new_frame;
    logic        new_pixel;
    logic        pixel_phase;

    always_comb begin
        if (mode.cf && mode.st) begin
            h_sel = 2'd0;
        end else if (mode.cf) begin
            h_sel = 2'd1;
        end else begin
            h_sel = 2'd2;     // 28 MHz crystal
        end

        if (mode.fd) begin
            v_sel = 2'd0;     // 60 Hz
        end else if (mode.st) begin
            v_sel = 2'd1;
        end else begin
            v_sel = 2'd2;
        end
    end

    always_comb begin
        h_total  = 13'(HTotal[h_sel] * ClksPerCycle);
        h_active = 13'(HActive[h_sel] * ClksPerCycle);
        h_start  = 13'(HStart[h_sel] * ClksPerCycle);
        h_sync   = 13'(HSync[h_sel] * ClksPerCycle);
        h_half   = h_total >> 1;         // Where interlace vsync edges sit
    end

    always_comb begin
        v_total  = 9'(VTotal[v_sel] + 1); // Includes the half line
        v_active = 9'(VActive[v_sel]);
        v_start  = 9'(VStart[v_sel]);
        v_last   = 9'(VTotal[v_sel] - VFrontPorch[v_sel] - 1); // Last line before front porch
        v_sync   = 9'(VSyncLines);

        // Even field is shifted down by one line
        if (!parity) begin
            v_start = v_start + 9'd1;
            v_last  = v_last + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            video_x   <= '0;
            video_y   <= '0;
            parity    <= 1'b1;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            new_line  <= 1'b0;
            new_frame <= 1'b0;
        end else begin
            new_line  <= 1'b0;
            new_frame <= 1'b0;

            if (video_x == h_total - 13'd1) begin
                video_x  <= '0;
                hsync    <= 1'b1;
                new_line <= 1'b1;

                if (video_y == v_total - 9'd1 && !parity) begin
                    // End of the longer even field, only reached when interlaced
                    video_y <= '0;
                    parity  <= 1'b1;
                    vsync   <= 1'b1;
                end else if (video_y == v_total - 9'd2 && parity) begin
                    video_y <= '0;
                    if (mode.sm) begin
                        parity <= 1'b0;   // Even field vsync starts mid line
                    end else begin
                        vsync <= 1'b1;
                    end
                end else begin
                    video_y   <= video_y + 9'd1;
                    new_frame <= (video_y == v_last);
                end
            end else begin
                video_x <= video_x + 13'd1;
            end

            if (video_x == h_sync - 13'd1) hsync <= 1'b0;  // Low from video_x == h_sync

            if (parity && video_y == v_sync) vsync <= 1'b0;

            // Half line offset vsync for the even field
            if (!parity && video_x == h_half) begin
                if (video_y == '0) vsync <= 1'b1;
                if (video_y == v_sync) vsync <= 1'b0;
            end
        end
    end

    // Blanks describe the previous counter value
    always_ff @(posedge clk) begin
        if (reset) begin
            hblank <= 1'b1;
            vblank <= 1'b1;
        end else begin
            hblank <= !(video_x >= h_start && video_x < h_start + h_active);
            vblank <= !(video_y >= v_start && video_y < v_start + v_active);
        end
    end

    // Every 2 clocks in high color mode, else every 4
    assign pixel_phase = mode.cm ? (video_x[0] == 1'b1) : (video_x[1:0] == 2'b01);
    assign new_pixel   = pixel_phase && !hblank && !vblank;

    assign beam = '{
        video_x:   video_x,
        video_y:   video_y,
        hsync:     hsync,
        vsync:     vsync,
        hblank:    hblank,
        vblank:    vblank,
        parity:    parity,
        new_line:  new_line,
        new_frame: new_frame,
        new_pixel: new_pixel
    };

endmodule

//--- display_regs.sv
// Write-only control registers; holds the border color and moves the display command live per frame
`timescale 1ns/10ps

module display_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  disp_pkg::reg_write_t reg_wr,
    input  logic                 new_frame,
    output disp_pkg::mode_t      mode,
    output disp_pkg::pixel_t     border
);
    import disp_pkg::*;

    reg_word_u wr_word;     // Same bits seen through both register layouts
    mode_t     pending;     // Last command written, waiting for the frame boundary
    logic      wr_command;
    logic      wr_border;

    assign wr_word    = reg_wr.data;
    assign wr_command = reg_wr.en && (reg_wr.addr == AddrCommand);
    assign wr_border  = reg_wr.en && (reg_wr.addr == AddrBorder);

    // Command capture
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else if (wr_command) begin
            pending <= wr_word.cmd.mode;
        end
    end

    // Live mode only changes between fields so no field is torn
    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= '0;
        end else if (new_frame) begin
            mode <= pending;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            border <= '0;     // Black
        end else if (wr_border) begin
            border <= wr_word.border;
        end
    end

endmodule

//--- disp_pkg.sv
// Shared timing constants, register map and bus types used by the display RTL and its testbench
package disp_pkg;

    localparam int ClksPerCycle = 16;    // Clocks per datasheet timing unit

    // Horizontal timing in datasheet units
    // Index 0 is 30 MHz at 360/720, index 1 is 30 MHz at 384/768, index 2 is 28 MHz
    localparam int HTotal  [3] = '{120, 120, 112};
    localparam int HActive [3] = '{90, 96, 90};
    localparam int HStart  [3] = '{23, 20, 19};
    localparam int HSync   [3] = '{9, 9, 8};

    // Vertical timing in lines
    // Index 0 is 60 Hz, index 1 is 50 Hz with NTSC height, index 2 is 50 Hz full height
    localparam int VTotal      [3] = '{262, 312, 312};
    localparam int VActive     [3] = '{240, 240, 280};
    localparam int VStart      [3] = '{18, 46, 26};
    localparam int VFrontPorch [3] = '{4, 26, 6};
    localparam int VSyncLines      = 3;

    localparam int PixFifoDepth = 8;                 // Also the source's starting credits
    localparam int PixPtrW      = $clog2(PixFifoDepth);

    localparam logic AddrCommand = 1'b0;
    localparam logic AddrBorder  = 1'b1;

    typedef struct packed {
        logic sm;    // Scan mode, 1 interlaced
        logic cf;    // Crystal, 1 is 30 MHz
        logic st;    // Standard, 1 is 360/720 pixels
        logic cm;    // Color mode, 1 is 2 clocks per pixel
        logic fd;    // Frame duration, 1 is 60 Hz
    } mode_t;

    typedef struct packed {
        logic [12:0] video_x;
        logic [8:0]  video_y;
        logic        hsync;
        logic        vsync;
        logic        hblank;
        logic        vblank;
        logic        parity;      // 1 odd field, always 1 when progressive
        logic        new_line;
        logic        new_frame;
        logic        new_pixel;
    } beam_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic [18:0] reserved;
        mode_t       mode;
    } cmd_word_t;

    // One register word, read as command or border color by address
    typedef union packed {
        cmd_word_t cmd;
        pixel_t    border;
    } reg_word_u;

    typedef struct packed {
        logic        en;
        logic        addr;
        logic [23:0] data;
    } reg_write_t;

endpackage
